/* common/decode_pkg.sv */
// Shared widths and encodings for the RV32I decode stage
// Only the base integer set is covered, so every instruction is 32 bits wide
// The encodings below are private to this core and need not match other cores

package decode_pkg;

	// --------------------
	// Widths

	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;
	localparam int W_REGADDR = 5;
	localparam int W_ALUSRC  = 1;
	localparam int W_ALUOP   = 4;
	localparam int W_MEMOP   = 4;
	localparam int W_BCOND   = 2;
	localparam int W_EXCEPT  = 3;

	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0080;
	localparam logic [W_ADDR-1:0] INSTR_BYTES  = 32'd4;

	// --------------------
	// Execute-stage control codes

	localparam logic [W_ALUSRC-1:0] ALUSRCA_RS1 = 1'b0;
	localparam logic [W_ALUSRC-1:0] ALUSRCA_PC  = 1'b1;
	localparam logic [W_ALUSRC-1:0] ALUSRCB_RS2 = 1'b0;
	localparam logic [W_ALUSRC-1:0] ALUSRCB_IMM = 1'b1;

	localparam logic [W_ALUOP-1:0] ALUOP_ADD = 4'd0;
	localparam logic [W_ALUOP-1:0] ALUOP_SUB = 4'd1;
	localparam logic [W_ALUOP-1:0] ALUOP_LT  = 4'd2;
	localparam logic [W_ALUOP-1:0] ALUOP_LTU = 4'd3;
	localparam logic [W_ALUOP-1:0] ALUOP_XOR = 4'd4;
	localparam logic [W_ALUOP-1:0] ALUOP_OR  = 4'd5;
	localparam logic [W_ALUOP-1:0] ALUOP_AND = 4'd6;
	localparam logic [W_ALUOP-1:0] ALUOP_SLL = 4'd7;
	localparam logic [W_ALUOP-1:0] ALUOP_SRL = 4'd8;
	localparam logic [W_ALUOP-1:0] ALUOP_SRA = 4'd9;
	// Passes operand B straight through, used by LUI and for store data
	localparam logic [W_ALUOP-1:0] ALUOP_RS2 = 4'd10;

	localparam logic [W_MEMOP-1:0] MEMOP_NONE = 4'd0;
	localparam logic [W_MEMOP-1:0] MEMOP_LB   = 4'd1;
	localparam logic [W_MEMOP-1:0] MEMOP_LH   = 4'd2;
	localparam logic [W_MEMOP-1:0] MEMOP_LW   = 4'd3;
	localparam logic [W_MEMOP-1:0] MEMOP_LBU  = 4'd4;
	localparam logic [W_MEMOP-1:0] MEMOP_LHU  = 4'd5;
	localparam logic [W_MEMOP-1:0] MEMOP_SB   = 4'd6;
	localparam logic [W_MEMOP-1:0] MEMOP_SH   = 4'd7;
	localparam logic [W_MEMOP-1:0] MEMOP_SW   = 4'd8;

	localparam logic [W_BCOND-1:0] BCOND_NEVER  = 2'd0;
	localparam logic [W_BCOND-1:0] BCOND_ZERO   = 2'd1;
	localparam logic [W_BCOND-1:0] BCOND_NZERO  = 2'd2;
	localparam logic [W_BCOND-1:0] BCOND_ALWAYS = 2'd3;

	localparam logic [W_EXCEPT-1:0] EXCEPT_NONE          = 3'd0;
	localparam logic [W_EXCEPT-1:0] EXCEPT_ECALL         = 3'd1;
	localparam logic [W_EXCEPT-1:0] EXCEPT_EBREAK        = 3'd2;
	localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_ILLEGAL = 3'd3;
	localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_FAULT   = 3'd4;

	// --------------------
	// Major opcodes, bits 6:2 of the instruction

	localparam logic [4:0] OPC_LOAD   = 5'b00000;
	localparam logic [4:0] OPC_FENCE  = 5'b00011;
	localparam logic [4:0] OPC_OP_IMM = 5'b00100;
	localparam logic [4:0] OPC_AUIPC  = 5'b00101;
	localparam logic [4:0] OPC_STORE  = 5'b01000;
	localparam logic [4:0] OPC_OP     = 5'b01100;
	localparam logic [4:0] OPC_LUI    = 5'b01101;
	localparam logic [4:0] OPC_BRANCH = 5'b11000;
	localparam logic [4:0] OPC_JALR   = 5'b11001;
	localparam logic [4:0] OPC_JAL    = 5'b11011;
	localparam logic [4:0] OPC_SYSTEM = 5'b11100;

	// One instruction word seen through each of the base formats.
	// The quad field is 2'b11 for every legal 32-bit encoding
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [4:0] opc;
			logic [1:0] quad;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [4:0]  opc;
			logic [1:0]  quad;
		} i;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rv_instr_u;

endpackage

/* decode_ctrl/decode_ctrl.sv */
// Decode PC, buffer consumption and the current-instruction lock
// A whole word is used at once, so use is either 0 or 2 halfwords
// Fetch must hold the jump target until a lock releases

`timescale 1ns/1ps

module decode_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic [1:0]                    fd_cir_err_i,
	input  logic [1:0]                    fd_cir_vld_i,
	input  logic                          x_stall_i,
	input  logic                          f_jump_now_i,
	input  logic [decode_pkg::W_ADDR-1:0] f_jump_target_i,
	input  logic                          x_jump_not_except_i,

	output logic [1:0]                    df_cir_use_o,
	output logic                          df_cir_flush_behind_o,
	output logic [decode_pkg::W_ADDR-1:0] d_pc_o,
	output logic                          d_starved_o,
	output logic                          bus_fault_o,
	output logic                          lock_hold_o
);

	import decode_pkg::*;

	logic              stall;
	logic              lock_start;
	logic              lock_next;
	logic              lock_q;
	logic [W_ADDR-1:0] pc_q;

	// An error is only reported on a halfword that fetch has marked valid
	assign bus_fault_o = (fd_cir_vld_i > 2'd0 && fd_cir_err_i[0]) ||
		(fd_cir_vld_i > 2'd1 && fd_cir_err_i[1]);

	assign d_starved_o = fd_cir_vld_i < 2'd2;
	assign stall = x_stall_i || d_starved_o;
	assign df_cir_use_o = stall ? 2'd0 : 2'd2;

	// --------------------
	// Current-instruction lock

	// The jump request cannot be gated by the stall without a combinational
	// path back to the bus, so the stalled word is kept and fetch refills
	// behind it. Once the stall clears the word finishes its side effects
	assign lock_start = f_jump_now_i && x_jump_not_except_i && stall;
	assign lock_next = (lock_q && stall) || lock_start;
	assign df_cir_flush_behind_o = lock_start && !lock_q;
	assign lock_hold_o = lock_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_q <= 1'b0;
		end else begin
			lock_q <= lock_next;
		end
	end

	// --------------------
	// Program counter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_VECTOR;
		end else if (f_jump_now_i && !lock_start) begin
			pc_q <= f_jump_target_i;
		end else if (lock_q && !stall) begin
			pc_q <= f_jump_target_i;
		end else if (!stall) begin
			pc_q <= pc_q + INSTR_BYTES;
		end
	end

	assign d_pc_o = pc_q;

endmodule

/* verilog/imm_offset_gen.sv */
// Immediate and address-offset selection for RV32I
// Purely combinational, selected on the major opcode alone
// Words with a bad opcode still produce a value, which the decoder squashes

`timescale 1ns/1ps

module imm_offset_gen (
	input  logic [decode_pkg::W_DATA-1:0] fd_cir_i,
	output logic [decode_pkg::W_DATA-1:0] d_imm_o,
	output logic [decode_pkg::W_ADDR-1:0] d_addr_offs_o
);

	import decode_pkg::*;

	rv_instr_u         instr;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_s;
	logic [W_DATA-1:0] imm_b;
	logic [W_DATA-1:0] imm_u;
	logic [W_DATA-1:0] imm_j;

	assign instr = fd_cir_i;

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
	assign imm_b = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
		instr.b.imm_4_1, 1'b0};
	assign imm_u = {instr.u.imm_31_12, 12'h000};
	assign imm_j = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
		instr.j.imm_10_1, 1'b0};

	// Jumps put the link value through the ALU as PC + immediate
	always_comb begin
		case (instr.r.opc)
		OPC_LUI, OPC_AUIPC: d_imm_o = imm_u;
		OPC_JAL, OPC_JALR:  d_imm_o = INSTR_BYTES;
		default:            d_imm_o = imm_i;
		endcase
	end

	always_comb begin
		case (instr.r.opc)
		OPC_JAL:            d_addr_offs_o = imm_j;
		OPC_BRANCH:         d_addr_offs_o = imm_b;
		OPC_STORE:          d_addr_offs_o = imm_s;
		OPC_JALR, OPC_LOAD: d_addr_offs_o = imm_i;
		default:            d_addr_offs_o = '0;
		endcase
	end

endmodule

/* opcode_decode/opcode_decode.sv */
// RV32I opcode decode into execute-stage controls
// FENCE is treated as a no-op, all CSR and privileged encodings are illegal
// Faults, illegal words and starvation squash every side effect

`timescale 1ns/1ps

module opcode_decode (
	input  logic [decode_pkg::W_DATA-1:0]    fd_cir_i,
	input  logic                             bus_fault_i,
	input  logic                             starved_i,
	input  logic                             lock_hold_i,

	output logic [decode_pkg::W_REGADDR-1:0] d_rs1_o,
	output logic [decode_pkg::W_REGADDR-1:0] d_rs2_o,
	output logic [decode_pkg::W_REGADDR-1:0] d_rd_o,
	output logic [decode_pkg::W_ALUSRC-1:0]  d_alusrc_a_o,
	output logic [decode_pkg::W_ALUSRC-1:0]  d_alusrc_b_o,
	output logic [decode_pkg::W_ALUOP-1:0]   d_aluop_o,
	output logic [decode_pkg::W_MEMOP-1:0]   d_memop_o,
	output logic [decode_pkg::W_BCOND-1:0]   d_branchcond_o,
	output logic                             d_addr_is_regoffs_o,
	output logic [decode_pkg::W_EXCEPT-1:0]  d_except_o
);

	import decode_pkg::*;

	rv_instr_u instr;
	logic      illegal;

	assign instr = fd_cir_i;

	always_comb begin
		// Defaults suit a register-register ALU op
		d_rs1_o = instr.r.rs1;
		d_rs2_o = instr.r.rs2;
		d_rd_o = instr.r.rd;
		d_alusrc_a_o = ALUSRCA_RS1;
		d_alusrc_b_o = ALUSRCB_RS2;
		d_aluop_o = ALUOP_ADD;
		d_memop_o = MEMOP_NONE;
		d_branchcond_o = BCOND_NEVER;
		d_addr_is_regoffs_o = 1'b0;
		d_except_o = EXCEPT_NONE;
		illegal = instr.r.quad != 2'b11;

		case (instr.r.opc)
		OPC_LOAD: begin
			d_addr_is_regoffs_o = 1'b1;
			d_rs2_o = '0;
			case (instr.r.funct3)
			3'd0:    d_memop_o = MEMOP_LB;
			3'd1:    d_memop_o = MEMOP_LH;
			3'd2:    d_memop_o = MEMOP_LW;
			3'd4:    d_memop_o = MEMOP_LBU;
			3'd5:    d_memop_o = MEMOP_LHU;
			default: illegal = 1'b1;
			endcase
		end
		OPC_STORE: begin
			d_addr_is_regoffs_o = 1'b1;
			d_aluop_o = ALUOP_RS2;
			d_rd_o = '0;
			case (instr.r.funct3)
			3'd0:    d_memop_o = MEMOP_SB;
			3'd1:    d_memop_o = MEMOP_SH;
			3'd2:    d_memop_o = MEMOP_SW;
			default: illegal = 1'b1;
			endcase
		end
		OPC_BRANCH: begin
			d_rd_o = '0;
			case (instr.r.funct3)
			3'd0, 3'd1: d_aluop_o = ALUOP_SUB;
			3'd4, 3'd5: d_aluop_o = ALUOP_LT;
			3'd6, 3'd7: d_aluop_o = ALUOP_LTU;
			default:    illegal = 1'b1;
			endcase
			// BNE, BLT and BLTU branch on a nonzero ALU result, the rest on zero
			d_branchcond_o = (instr.r.funct3[0] ^ instr.r.funct3[2]) ?
				BCOND_NZERO : BCOND_ZERO;
		end
		OPC_JAL, OPC_JALR: begin
			d_branchcond_o = BCOND_ALWAYS;
			d_alusrc_a_o = ALUSRCA_PC;
			d_alusrc_b_o = ALUSRCB_IMM;
			d_rs2_o = '0;
			if (instr.r.opc == OPC_JAL) begin
				d_rs1_o = '0;
			end else begin
				d_addr_is_regoffs_o = 1'b1;
				illegal = illegal || instr.r.funct3 != 3'd0;
			end
		end
		OPC_LUI, OPC_AUIPC: begin
			d_aluop_o = (instr.r.opc == OPC_LUI) ? ALUOP_RS2 : ALUOP_ADD;
			d_alusrc_a_o = (instr.r.opc == OPC_LUI) ? ALUSRCA_RS1 : ALUSRCA_PC;
			d_alusrc_b_o = ALUSRCB_IMM;
			d_rs1_o = '0;
			d_rs2_o = '0;
		end
		OPC_OP_IMM: begin
			d_alusrc_b_o = ALUSRCB_IMM;
			d_rs2_o = '0;
			case (instr.r.funct3)
			3'd0: d_aluop_o = ALUOP_ADD;
			3'd1: d_aluop_o = ALUOP_SLL;
			3'd2: d_aluop_o = ALUOP_LT;
			3'd3: d_aluop_o = ALUOP_LTU;
			3'd4: d_aluop_o = ALUOP_XOR;
			3'd5: d_aluop_o = instr.r.funct7[5] ? ALUOP_SRA : ALUOP_SRL;
			3'd6: d_aluop_o = ALUOP_OR;
			3'd7: d_aluop_o = ALUOP_AND;
			endcase
			// Shift immediates keep funct7, only SRAI may set bit 5 of it
			if (instr.r.funct3 == 3'd1 && instr.r.funct7 != 7'h00)
				illegal = 1'b1;
			if (instr.r.funct3 == 3'd5 && instr.r.funct7 != 7'h00 && instr.r.funct7 != 7'h20)
				illegal = 1'b1;
		end
		OPC_OP: begin
			case ({instr.r.funct7, instr.r.funct3})
			{7'h00, 3'd0}: d_aluop_o = ALUOP_ADD;
			{7'h20, 3'd0}: d_aluop_o = ALUOP_SUB;
			{7'h00, 3'd1}: d_aluop_o = ALUOP_SLL;
			{7'h00, 3'd2}: d_aluop_o = ALUOP_LT;
			{7'h00, 3'd3}: d_aluop_o = ALUOP_LTU;
			{7'h00, 3'd4}: d_aluop_o = ALUOP_XOR;
			{7'h00, 3'd5}: d_aluop_o = ALUOP_SRL;
			{7'h20, 3'd5}: d_aluop_o = ALUOP_SRA;
			{7'h00, 3'd6}: d_aluop_o = ALUOP_OR;
			{7'h00, 3'd7}: d_aluop_o = ALUOP_AND;
			default:       illegal = 1'b1;
			endcase
		end
		OPC_FENCE: begin
			d_rs2_o = '0;
			illegal = illegal || instr.r.funct3 != 3'd0;
		end
		OPC_SYSTEM: begin
			d_rs1_o = '0;
			d_rs2_o = '0;
			d_rd_o = '0;
			if (instr.i.rs1 != '0 || instr.i.funct3 != 3'd0 || instr.i.rd != '0)
				illegal = 1'b1;
			else if (instr.i.imm == 12'h000)
				d_except_o = EXCEPT_ECALL;
			else if (instr.i.imm == 12'h001)
				d_except_o = EXCEPT_EBREAK;
			else
				illegal = 1'b1;
		end
		default: illegal = 1'b1;
		endcase

		// --------------------
		// Squash

		if (illegal || starved_i || bus_fault_i) begin
			d_rs1_o = '0;
			d_rs2_o = '0;
			d_rd_o = '0;
			d_memop_o = MEMOP_NONE;
			d_branchcond_o = BCOND_NEVER;
			d_except_o = EXCEPT_NONE;
			// Address bus then reads as zero when the register file resets
			d_addr_is_regoffs_o = 1'b1;
			if (bus_fault_i)
				d_except_o = EXCEPT_INSTR_FAULT;
			else if (illegal && !starved_i)
				d_except_o = EXCEPT_INSTR_ILLEGAL;
		end
		// The locked word's jump has already been taken
		if (lock_hold_i)
			d_branchcond_o = BCOND_NEVER;
	end

endmodule

/* verilog/decode_stage.sv */
// RV32I decode stage, wiring only
// Fetch must present whole 32-bit words, valid count in halfwords (0 to 2)
// All decode outputs are combinational from the current instruction word

`timescale 1ns/1ps

module decode_stage (
	input  logic                            clk,
	input  logic                            rst_n,

	input  logic [decode_pkg::W_DATA-1:0]   fd_cir_i,
	input  logic [1:0]                      fd_cir_err_i,
	input  logic [1:0]                      fd_cir_vld_i,
	output logic [1:0]                      df_cir_use_o,
	output logic                            df_cir_flush_behind_o,
	output logic [decode_pkg::W_ADDR-1:0]   d_pc_o,

	output logic                            d_starved_o,
	input  logic                            x_stall_i,
	input  logic                            f_jump_now_i,
	input  logic [decode_pkg::W_ADDR-1:0]   f_jump_target_i,
	input  logic                            x_jump_not_except_i,

	output logic [decode_pkg::W_DATA-1:0]   d_imm_o,
	output logic [decode_pkg::W_REGADDR-1:0] d_rs1_o,
	output logic [decode_pkg::W_REGADDR-1:0] d_rs2_o,
	output logic [decode_pkg::W_REGADDR-1:0] d_rd_o,
	output logic [decode_pkg::W_ALUSRC-1:0] d_alusrc_a_o,
	output logic [decode_pkg::W_ALUSRC-1:0] d_alusrc_b_o,
	output logic [decode_pkg::W_ALUOP-1:0]  d_aluop_o,
	output logic [decode_pkg::W_MEMOP-1:0]  d_memop_o,
	output logic [decode_pkg::W_BCOND-1:0]  d_branchcond_o,
	output logic [decode_pkg::W_ADDR-1:0]   d_addr_offs_o,
	output logic                            d_addr_is_regoffs_o,
	output logic [decode_pkg::W_EXCEPT-1:0] d_except_o
);

	logic bus_fault;
	logic starved;
	logic lock_hold;

	assign d_starved_o = starved;

	decode_ctrl u_ctrl (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.fd_cir_err_i          (fd_cir_err_i),
		.fd_cir_vld_i          (fd_cir_vld_i),
		.x_stall_i             (x_stall_i),
		.f_jump_now_i          (f_jump_now_i),
		.f_jump_target_i       (f_jump_target_i),
		.x_jump_not_except_i   (x_jump_not_except_i),
		.df_cir_use_o          (df_cir_use_o),
		.df_cir_flush_behind_o (df_cir_flush_behind_o),
		.d_pc_o                (d_pc_o),
		.d_starved_o           (starved),
		.bus_fault_o           (bus_fault),
		.lock_hold_o           (lock_hold)
	);

	imm_offset_gen u_imm (
		.fd_cir_i      (fd_cir_i),
		.d_imm_o       (d_imm_o),
		.d_addr_offs_o (d_addr_offs_o)
	);

	opcode_decode u_opc (
		.fd_cir_i            (fd_cir_i),
		.bus_fault_i         (bus_fault),
		.starved_i           (starved),
		.lock_hold_i         (lock_hold),
		.d_rs1_o             (d_rs1_o),
		.d_rs2_o             (d_rs2_o),
		.d_rd_o              (d_rd_o),
		.d_alusrc_a_o        (d_alusrc_a_o),
		.d_alusrc_b_o        (d_alusrc_b_o),
		.d_aluop_o           (d_aluop_o),
		.d_memop_o           (d_memop_o),
		.d_branchcond_o      (d_branchcond_o),
		.d_addr_is_regoffs_o (d_addr_is_regoffs_o),
		.d_except_o          (d_except_o)
	);

endmodule

/* verif/decode_stage_assertions.sv */
// Protocol properties of the decode stage, bound to every decode_stage instance
// Sampled on the rising clock edge and disabled during reset

`timescale 1ns/1ps

module decode_stage_assertions (
	input logic        clk,
	input logic        rst_n,
	input logic        x_stall_i,
	input logic        starved_i,
	input logic        jump_i,
	input logic [1:0]  use_i,
	input logic        flush_i,
	input logic [31:0] pc_i
);

	// --------------------
	// Buffer use and lock

	no_use_when_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		(x_stall_i || starved_i) |-> use_i == 2'd0)
		else $error("Buffer used while stalled or starved");

	flush_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> !flush_i)
		else $error("Flush-behind held for two cycles");

	// A jump is the only thing that moves the PC out of a stall
	pc_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		((x_stall_i || starved_i) && !jump_i) |=> $stable(pc_i))
		else $error("PC moved during a stall");

endmodule

bind decode_stage decode_stage_assertions u_assertions (
	.clk       (clk),
	.rst_n     (rst_n),
	.x_stall_i (x_stall_i),
	.starved_i (d_starved_o),
	.jump_i    (f_jump_now_i),
	.use_i     (df_cir_use_o),
	.flush_i   (df_cir_flush_behind_o),
	.pc_i      (d_pc_o)
);

/* verif/tb_decode_stage.sv */
// Testbench for the RV32I decode stage
// Random stimulus from a fixed LFSR seed, checked against a model of the decode rules
// Inputs change 1 ns after the rising edge, outputs are sampled 3 ns after it

`timescale 1ns/1ps

module tb_decode_stage;

	import decode_pkg::*;

	localparam int N_SEQ = 300;
	localparam int N_BAD = 200;
	localparam int N_IMM = 200;
	localparam int N_JMP = 300;
	localparam int TOTAL_CYCLES = 4 + 4 + N_SEQ + N_BAD + N_IMM + N_JMP;
	localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES;

	logic                 clk;
	logic                 rst_n;
	logic [W_DATA-1:0]    fd_cir_i;
	logic [1:0]           fd_cir_err_i;
	logic [1:0]           fd_cir_vld_i;
	logic                 x_stall_i;
	logic                 f_jump_now_i;
	logic [W_ADDR-1:0]    f_jump_target_i;
	logic                 x_jump_not_except_i;
	logic [1:0]           df_cir_use_o;
	logic                 df_cir_flush_behind_o;
	logic [W_ADDR-1:0]    d_pc_o;
	logic                 d_starved_o;
	logic [W_DATA-1:0]    d_imm_o;
	logic [W_REGADDR-1:0] d_rs1_o;
	logic [W_REGADDR-1:0] d_rs2_o;
	logic [W_REGADDR-1:0] d_rd_o;
	logic [W_ALUSRC-1:0]  d_alusrc_a_o;
	logic [W_ALUSRC-1:0]  d_alusrc_b_o;
	logic [W_ALUOP-1:0]   d_aluop_o;
	logic [W_MEMOP-1:0]   d_memop_o;
	logic [W_BCOND-1:0]   d_branchcond_o;
	logic [W_ADDR-1:0]    d_addr_offs_o;
	logic                 d_addr_is_regoffs_o;
	logic [W_EXCEPT-1:0]  d_except_o;

	// Model state and counters
	logic [31:0]       lfsr;
	logic [W_ADDR-1:0] pc_m;
	logic              lock_m;
	int                checks;
	int                errors;
	int                test_checks;
	int                test_errors;
	int                cycles;

	decode_stage uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// --------------------
	// Random numbers

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Builds a legal RV32I word from random fields
	function automatic logic [31:0] legal_word();
		logic [4:0] opcs [11];
		logic [4:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] rs_bits;
		logic [31:0] rd_bits;
		logic [31:0] w;
		opcs = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_LUI,
			OPC_AUIPC, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYSTEM};
		opc = opcs[rand_bits(8) % 11];
		f3 = rand_bits(3);
		f7 = rand_bits(7);
		case (opc)
		OPC_LOAD:   if (f3 == 3 || f3 > 5) f3 = 3'd2;
		OPC_STORE:  if (f3 > 2) f3 = 3'd0;
		OPC_BRANCH: if (f3 == 2 || f3 == 3) f3 = f3 + 3'd4;
		OPC_JALR, OPC_FENCE: f3 = 3'd0;
		OPC_OP_IMM: begin
			if (f3 == 1 || f3 == 5)
				f7 = (f3 == 5 && f7[0]) ? 7'h20 : 7'h00;
		end
		OPC_OP: f7 = ((f3 == 0 || f3 == 5) && f7[0]) ? 7'h20 : 7'h00;
		default: ;
		endcase
		rs_bits = rand_bits(10);
		rd_bits = rand_bits(5);
		w = {f7, rs_bits[9:0], f3, rd_bits[4:0], opc, 2'b11};
		if (opc == OPC_SYSTEM)
			w = rand_bits(1) ? 32'h0010_0073 : 32'h0000_0073;
		return w;
	endfunction

	// --------------------
	// Checks

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("%s done: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// Applies the decode rules to the word and compares every output
	task automatic check_decode(input logic [31:0] w, input logic fault,
		input logic starved, input logic lock);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] opc;
		logic [4:0] rs1, rs2, rd;
		logic [W_ALUSRC-1:0] asa, asb;
		logic [W_ALUOP-1:0] aop;
		logic [W_MEMOP-1:0] mop;
		logic [W_BCOND-1:0] bc;
		logic [W_EXCEPT-1:0] ex;
		logic ro, ill, squash;
		logic [31:0] ii, is, ib, iu, ij, imm, offs;
		f3 = w[14:12];
		f7 = w[31:25];
		opc = w[6:2];
		rs1 = w[19:15];
		rs2 = w[24:20];
		rd = w[11:7];
		asa = ALUSRCA_RS1;
		asb = ALUSRCB_RS2;
		aop = ALUOP_ADD;
		mop = MEMOP_NONE;
		bc = BCOND_NEVER;
		ex = EXCEPT_NONE;
		ro = 1'b0;
		ill = w[1:0] != 2'b11;
		ii = {{20{w[31]}}, w[31:20]};
		is = {{20{w[31]}}, w[31:25], w[11:7]};
		ib = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		iu = {w[31:12], 12'h000};
		ij = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		imm = ii;
		offs = '0;
		case (opc)
		OPC_LOAD: begin
			ro = 1'b1;
			rs2 = '0;
			offs = ii;
			case (f3)
			0: mop = MEMOP_LB;
			1: mop = MEMOP_LH;
			2: mop = MEMOP_LW;
			4: mop = MEMOP_LBU;
			5: mop = MEMOP_LHU;
			default: ill = 1'b1;
			endcase
		end
		OPC_STORE: begin
			ro = 1'b1;
			aop = ALUOP_RS2;
			rd = '0;
			offs = is;
			if (f3 == 0) mop = MEMOP_SB;
			else if (f3 == 1) mop = MEMOP_SH;
			else if (f3 == 2) mop = MEMOP_SW;
			else ill = 1'b1;
		end
		OPC_BRANCH: begin
			rd = '0;
			offs = ib;
			ill = ill || f3 == 2 || f3 == 3;
			aop = (f3 < 2) ? ALUOP_SUB : (f3 < 6) ? ALUOP_LT : ALUOP_LTU;
			bc = (f3 == 1 || f3 == 4 || f3 == 6) ? BCOND_NZERO : BCOND_ZERO;
		end
		OPC_JAL, OPC_JALR: begin
			bc = BCOND_ALWAYS;
			asa = ALUSRCA_PC;
			asb = ALUSRCB_IMM;
			rs2 = '0;
			imm = 32'd4;
			if (opc == OPC_JAL) begin
				rs1 = '0;
				offs = ij;
			end else begin
				ro = 1'b1;
				offs = ii;
				ill = ill || f3 != 0;
			end
		end
		OPC_LUI, OPC_AUIPC: begin
			asb = ALUSRCB_IMM;
			rs1 = '0;
			rs2 = '0;
			imm = iu;
			if (opc == OPC_LUI)
				aop = ALUOP_RS2;
			else
				asa = ALUSRCA_PC;
		end
		OPC_OP_IMM, OPC_OP: begin
			case (f3)
			0: aop = ALUOP_ADD;
			1: aop = ALUOP_SLL;
			2: aop = ALUOP_LT;
			3: aop = ALUOP_LTU;
			4: aop = ALUOP_XOR;
			5: aop = ALUOP_SRL;
			6: aop = ALUOP_OR;
			7: aop = ALUOP_AND;
			endcase
			if (opc == OPC_OP_IMM) begin
				asb = ALUSRCB_IMM;
				rs2 = '0;
				if (f3 == 5 && f7 == 7'h20) aop = ALUOP_SRA;
				if (f3 == 1 && f7 != 0) ill = 1'b1;
				if (f3 == 5 && f7 != 0 && f7 != 7'h20) ill = 1'b1;
			end else begin
				if (f7 == 7'h20 && f3 == 0) aop = ALUOP_SUB;
				else if (f7 == 7'h20 && f3 == 5) aop = ALUOP_SRA;
				else if (f7 != 0) ill = 1'b1;
			end
		end
		OPC_FENCE: begin
			rs2 = '0;
			ill = ill || f3 != 0;
		end
		OPC_SYSTEM: begin
			rs1 = '0;
			rs2 = '0;
			rd = '0;
			if (w[31:7] == '0) ex = EXCEPT_ECALL;
			else if (w[31:7] == {12'h001, 13'h0}) ex = EXCEPT_EBREAK;
			else ill = 1'b1;
		end
		default: ill = 1'b1;
		endcase

		squash = ill || starved || fault;
		if (squash) begin
			rs1 = '0;
			rs2 = '0;
			rd = '0;
			mop = MEMOP_NONE;
			bc = BCOND_NEVER;
			ro = 1'b1;
			ex = fault ? EXCEPT_INSTR_FAULT :
				(ill && !starved) ? EXCEPT_INSTR_ILLEGAL : EXCEPT_NONE;
		end else begin
			// ALU controls of a squashed word carry no meaning
			check_val("aluop", d_aluop_o, aop);
			check_val("alusrc_a", d_alusrc_a_o, asa);
			check_val("alusrc_b", d_alusrc_b_o, asb);
		end
		if (lock)
			bc = BCOND_NEVER;
		check_val("rs1", d_rs1_o, rs1);
		check_val("rs2", d_rs2_o, rs2);
		check_val("rd", d_rd_o, rd);
		check_val("memop", d_memop_o, mop);
		check_val("branchcond", d_branchcond_o, bc);
		check_val("addr_is_regoffs", d_addr_is_regoffs_o, ro);
		check_val("except", d_except_o, ex);
		check_val("imm", d_imm_o, imm);
		check_val("addr_offs", d_addr_offs_o, offs);
	endtask

	// One clock cycle: drive, check, then advance the model to the next edge
	task automatic run_cycle(input logic [31:0] w, input logic [1:0] vld,
		input logic [1:0] err, input logic stall, input logic jump,
		input logic xjne, input logic [31:0] target);
		logic starved, st, fault, lstart, lnext;
		@(posedge clk);
		#1;
		fd_cir_i = w;
		fd_cir_vld_i = vld;
		fd_cir_err_i = err;
		x_stall_i = stall;
		f_jump_now_i = jump;
		x_jump_not_except_i = xjne;
		f_jump_target_i = target;
		#2;
		starved = vld < 2;
		st = stall || starved;
		fault = (vld >= 1 && err[0]) || (vld == 2 && err[1]);
		lstart = jump && xjne && st;
		lnext = (lock_m && st) || lstart;
		check_val("pc", d_pc_o, pc_m);
		check_val("starved", d_starved_o, starved);
		check_val("use", df_cir_use_o, st ? 0 : 2);
		check_val("flush_behind", df_cir_flush_behind_o, lstart && !lock_m);
		check_decode(w, fault, starved, lock_m);
		if (jump && !lstart)
			pc_m = target;
		else if (lock_m && !st)
			pc_m = target;
		else if (!st && !lnext)
			pc_m = pc_m + 32'd4;
		lock_m = lnext;
	endtask

	// --------------------
	// Tests

	initial begin
		logic [31:0] w;
		logic [31:0] tgt;
		logic stall;
		logic jump;
		lfsr = 32'h0bfd_182b;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		cycles = 0;
		rst_n = 1'b0;
		fd_cir_i = '0;
		fd_cir_err_i = '0;
		fd_cir_vld_i = '0;
		x_stall_i = 1'b0;
		f_jump_now_i = 1'b0;
		f_jump_target_i = '0;
		x_jump_not_except_i = 1'b0;
		pc_m = RESET_VECTOR;
		lock_m = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		repeat (4) run_cycle('0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, '0);
		end_test("Reset");

		// Mostly full buffer, some stalls and starved cycles
		for (int n = 0; n < N_SEQ; n++) begin
			stall = rand_bits(2) == 0;
			run_cycle(legal_word(), rand_bits(2) == 0 ? rand_bits(1) : 2'd2,
				2'd0, stall, 1'b0, 1'b0, '0);
		end
		end_test("Sequential flow");

		// Raw words with random error bits and valid counts
		for (int n = 0; n < N_BAD; n++) begin
			w = rand_bits(1) ? rand_bits(32) : legal_word();
			run_cycle(w, rand_bits(2) % 3, rand_bits(2), rand_bits(1), 1'b0, 1'b0, '0);
		end
		end_test("Illegal and fault");

		for (int n = 0; n < N_IMM; n++)
			run_cycle(legal_word(), 2'd2, 2'd0, 1'b0, 1'b0, 1'b0, '0);
		end_test("Immediates");

		// Fetch holds the target while a lock is pending
		tgt = '0;
		for (int n = 0; n < N_JMP; n++) begin
			stall = rand_bits(1);
			jump = !lock_m && rand_bits(2) == 0;
			if (jump)
				tgt = rand_bits(30) << 2;
			run_cycle(legal_word(), 2'd2, 2'd0, stall, jump, rand_bits(2) != 0, tgt);
		end
		end_test("Jumps");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* decode_stage.f */
common/decode_pkg.sv
decode_ctrl/decode_ctrl.sv
verilog/imm_offset_gen.sv
opcode_decode/opcode_decode.sv
verilog/decode_stage.sv
verif/decode_stage_assertions.sv
verif/tb_decode_stage.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert
FILELIST  ?= decode_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail if $(LOG) reports a failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, LOG, FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
